//--- all.f
+incdir+verification
logic/rvIsaPkg.sv
logic/rvPipePkg.sv
logic/issueIf.sv
logic/aluUnit.sv
logic/regFile.sv
logic/fetchUnit.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/rvCore.sv
verification/rvCoreTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= rvCoreTb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= all.f
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard verification/*.svh)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -qx 'test passed' $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verification/rvEncode.svh
// I-type word in the OP-IMM group
function automatic wordT encImm(input logic [2:0] f3, input regAddrT rd, input regAddrT rs1,
                                input logic [11:0] imm);
    return {imm, rs1, f3, rd, 7'b0010011};
endfunction

// R-type word in the OP group with alt as bit 30
function automatic wordT encReg(input logic [2:0] f3, input logic alt, input regAddrT rd,
                                input regAddrT rs1, input regAddrT rs2);
    return {1'b0, alt, 5'b00000, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic wordT sext12(input logic [11:0] imm);
    return {{20{imm[11]}}, imm};
endfunction

// Expected result by funct3 and alt bit
function automatic wordT refAlu(input logic [2:0] f3, input logic alt, input wordT a,
                                input wordT b);
    logic [4:0] sh;
    logic       less;
    sh = b[4:0];                                     // Low five bits only
    less = (a[31] != b[31]) ? a[31] : (a < b);       // Signed compare by sign bits
    case (f3)
        3'b000:  return alt ? a - b : a + b;
        3'b001:  return a << sh;
        3'b010:  return {31'b0, less};
        3'b011:  return {31'b0, a < b};              // Unsigned
        3'b100:  return a ^ b;
        3'b101:  return alt ? ((a >> sh) | ({32{a[31]}} & ~(32'hFFFF_FFFF >> sh))) : a >> sh;
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

//--- verification/rvCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module rvCoreTb;
    import rvIsaPkg::*;

    logic    clk;
    logic    rst_n;
    wordT    imemAddr;
    wordT    imemInsn;
    logic    retireValid;
    regAddrT retireReg;
    wordT    retireData;

    wordT    imem [0:255];       // Program memory by word address
    wordT    model [0:31];       // Reference register file
    regAddrT expReg [$];         // Expected retires in program order
    wordT    expData [$];
    int      expCycle [$];
    int      progLen;
    string   testName;
    int      testErrs;
    int      totalErrs;
    int      testsFailed;
    int      testsRun;

    always #20 clk = ~clk;       // 40 ns period

    assign imemInsn = imem[imemAddr[9:2]];   // Answers in the same cycle

    rvCore rvCore_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .imemAddr    (imemAddr),
        .imemInsn    (imemInsn),
        .retireValid (retireValid),
        .retireReg   (retireReg),
        .retireData  (retireData)
    );

    // ------------------------------
    // Program building

    task automatic clearProgram(input string name);
        testName = name;
        testErrs = 0;
        progLen  = 0;
        for (int i = 0; i < 256; i++)
            imem[i] = encImm(3'b000, 5'd0, 5'd0, 12'd0);   // NOP fill
        for (int r = 0; r < 32; r++)
            model[r] = '0;
        expReg.delete();
        expData.delete();
        expCycle.delete();
    endtask

    // One word per slot with its retire due four cycles after fetch
    task automatic pushWord(input wordT insn, input regAddrT rd, input wordT value);
        imem[progLen] = insn;
        if (rd != 5'd0) begin
            expReg.push_back(rd);
            expData.push_back(value);
            expCycle.push_back(progLen + 4);
            model[rd] = value;
        end
        progLen++;
    endtask

    task automatic addImm(input logic [2:0] f3, input regAddrT rd, input regAddrT rs1,
                          input logic [11:0] imm);
        logic alt;
        alt = (f3 == 3'b101) ? imm[10] : 1'b0;   // Alt bit only for right shifts
        pushWord(encImm(f3, rd, rs1, imm), rd, refAlu(f3, alt, model[rs1], sext12(imm)));
    endtask

    task automatic addShiftImm(input logic [2:0] f3, input logic alt, input regAddrT rd,
                               input regAddrT rs1, input logic [4:0] shamt);
        addImm(f3, rd, rs1, {1'b0, alt, 5'b00000, shamt});
    endtask

    task automatic addReg(input logic [2:0] f3, input logic alt, input regAddrT rd,
                          input regAddrT rs1, input regAddrT rs2);
        pushWord(encReg(f3, alt, rd, rs1, rs2), rd, refAlu(f3, alt, model[rs1], model[rs2]));
    endtask

    // Unsupported word with nothing expected
    task automatic addRaw(input wordT insn);
        imem[progLen] = insn;
        progLen++;
    endtask

    // ------------------------------
    // Running and checking

    task automatic reportMismatch(input string what, input wordT expVal, input wordT actVal);
        $display("ERR %s %s: expected %h actual %h", testName, what, expVal, actVal);
        testErrs++;
    endtask

    task automatic pulseReset();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (2) begin
            @(negedge clk);
            if (retireValid !== 1'b0)
                reportMismatch("retireValid in reset", 32'd0, 32'(retireValid));
            if (imemAddr !== 32'd0)
                reportMismatch("imemAddr in reset", 32'd0, imemAddr);
        end
        @(posedge clk);
        rst_n <= 1'b1;                 // Cycle 0 starts here
    endtask

    task automatic runProgram();
        int cyc;
        bit busy;
        pulseReset();
        cyc  = 0;
        busy = 1'b1;
        while (busy) begin
            @(negedge clk);            // Outputs settled mid-cycle
            if (imemAddr !== wordT'(cyc * 4))
                reportMismatch("imemAddr", wordT'(cyc * 4), imemAddr);
            if (retireValid === 1'b1) begin
                if (expReg.size() == 0) begin
                    $display("%s: unexpected retire of x%0d in cycle %0d",
                             testName, retireReg, cyc);
                    testErrs++;
                end else begin
                    if (expCycle[0] != cyc)
                        reportMismatch("retire cycle", wordT'(expCycle[0]), wordT'(cyc));
                    if (retireReg !== expReg[0])
                        reportMismatch("retireReg", 32'(expReg[0]), 32'(retireReg));
                    if (retireData !== expData[0])
                        reportMismatch("retireData", expData[0], retireData);
                    void'(expReg.pop_front());
                    void'(expData.pop_front());
                    void'(expCycle.pop_front());
                end
            end else if (expReg.size() > 0 && expCycle[0] <= cyc) begin
                $display("%s: no retire of x%0d in cycle %0d", testName, expReg[0], cyc);
                testErrs++;
                void'(expReg.pop_front());
                void'(expData.pop_front());
                void'(expCycle.pop_front());
            end
            cyc++;
            if (expReg.size() == 0 && cyc > progLen + 4) begin
                busy = 1'b0;           // Whole program drained
            end else if (cyc > progLen + 40) begin
                $display("%s: timeout waiting for the program to retire", testName);
                testErrs++;
                busy = 1'b0;
            end
        end
    endtask

    task automatic finishTest();
        testsRun++;
        totalErrs += testErrs;
        if (testErrs == 0) begin
            $display("%s: PASS", testName);
        end else begin
            $display("%s: FAIL with %0d errors", testName, testErrs);
            testsFailed++;
        end
    endtask

    // ------------------------------
    // Directed tests

    task automatic resetAndFetch();
        clearProgram("reset_fetch");
        for (int i = 1; i < 9; i++)
            addImm(3'b000, regAddrT'(i), 5'd0, 12'($urandom()));
        pulseReset();                  // Fill pass, retires not checked
        repeat (6) @(negedge clk);     // Every stage now holds a write
        runProgram();                  // Reset lands on a full pipeline
        finishTest();
    endtask

    task automatic immediateOps();
        clearProgram("imm_ops");
        addImm(3'b000, 5'd1, 5'd0, 12'($urandom()));
        addImm(3'b000, 5'd2, 5'd0, {1'b1, 11'($urandom())});       // Negative source
        addImm(3'b000, 5'd3, 5'd1, 12'($urandom()));               // ADDI
        addImm(3'b010, 5'd4, 5'd2, 12'($urandom()));               // SLTI
        addImm(3'b011, 5'd5, 5'd2, 12'($urandom()));               // SLTIU
        addImm(3'b100, 5'd6, 5'd1, 12'($urandom()));               // XORI
        addImm(3'b110, 5'd7, 5'd2, 12'($urandom()));               // ORI
        addImm(3'b111, 5'd8, 5'd1, 12'($urandom()));               // ANDI
        addShiftImm(3'b001, 1'b0, 5'd9, 5'd1, 5'($urandom()) | 5'd1);     // SLLI
        addShiftImm(3'b101, 1'b0, 5'd10, 5'd2, 5'($urandom()) | 5'd1);    // SRLI
        addShiftImm(3'b101, 1'b1, 5'd11, 5'd2, 5'($urandom()) | 5'd1);    // SRAI
        addImm(3'b000, 5'd12, 5'd2, {2'b01, 10'($urandom())});     // Bit 30 set but still ADD
        runProgram();
        finishTest();
    endtask

    task automatic registerOps();
        clearProgram("reg_ops");
        addImm(3'b000, 5'd1, 5'd0, {1'b1, 11'($urandom())});
        addShiftImm(3'b001, 1'b0, 5'd1, 5'd1, 5'd19);
        addImm(3'b110, 5'd1, 5'd1, {1'b0, 11'($urandom())});       // x1 stays negative
        addImm(3'b000, 5'd2, 5'd0, {1'b0, 11'($urandom()) | 11'd1});
        addImm(3'b000, 5'd3, 5'd0, {7'b0000001, 5'($urandom()) | 5'd1});  // Amount 33 to 63
        addReg(3'b000, 1'b0, 5'd4, 5'd1, 5'd2);    // ADD
        addReg(3'b000, 1'b1, 5'd5, 5'd1, 5'd2);    // SUB
        addReg(3'b001, 1'b0, 5'd6, 5'd2, 5'd3);    // SLL
        addReg(3'b010, 1'b0, 5'd7, 5'd1, 5'd2);    // SLT sees negative below positive
        addReg(3'b011, 1'b0, 5'd8, 5'd1, 5'd2);    // SLTU sees negative as large
        addReg(3'b100, 1'b0, 5'd9, 5'd1, 5'd2);    // XOR
        addReg(3'b101, 1'b0, 5'd10, 5'd1, 5'd3);   // SRL
        addReg(3'b101, 1'b1, 5'd11, 5'd1, 5'd3);   // SRA
        addReg(3'b110, 1'b0, 5'd12, 5'd1, 5'd2);   // OR
        addReg(3'b111, 1'b0, 5'd13, 5'd1, 5'd2);   // AND
        runProgram();
        finishTest();
    endtask

    task automatic forwardingChain();
        clearProgram("forwarding");
        addImm(3'b000, 5'd1, 5'd0, 12'($urandom()));
        addImm(3'b000, 5'd5, 5'd0, 12'($urandom()));
        addImm(3'b000, 5'd6, 5'd0, 12'($urandom()));
        addReg(3'b000, 1'b0, 5'd2, 5'd1, 5'd6);    // x1 three back and x6 one back
        addReg(3'b000, 1'b1, 5'd3, 5'd2, 5'd5);    // x5 three back
        addReg(3'b100, 1'b0, 5'd4, 5'd3, 5'd2);    // One and two back
        addReg(3'b110, 1'b0, 5'd7, 5'd2, 5'd4);
        addReg(3'b001, 1'b0, 5'd8, 5'd3, 5'd7);
        addImm(3'b000, 5'd9, 5'd0, 12'($urandom()));
        addImm(3'b000, 5'd9, 5'd9, 12'($urandom()));
        addReg(3'b000, 1'b0, 5'd10, 5'd9, 5'd9);   // Newest x9 must win
        runProgram();
        finishTest();
    endtask

    task automatic suppressedWrites();
        clearProgram("suppressed");
        addImm(3'b000, 5'd1, 5'd0, {1'b0, 11'($urandom()) | 11'd1});
        addImm(3'b000, 5'd0, 5'd1, 12'($urandom()));       // Write to x0
        addReg(3'b000, 1'b0, 5'd0, 5'd1, 5'd1);
        addReg(3'b110, 1'b0, 5'd2, 5'd0, 5'd0);            // x0 one and two back
        addReg(3'b000, 1'b0, 5'd3, 5'd0, 5'd1);
        addRaw({12'd0, 5'd0, 3'b010, 5'd5, 7'b0000011});   // LW x5
        addRaw({20'h12345, 5'd6, 7'b0110111});             // LUI x6
        addReg(3'b000, 1'b0, 5'd7, 5'd5, 5'd6);            // Both still zero
        runProgram();
        finishTest();
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        totalErrs   = 0;
        testsFailed = 0;
        testsRun    = 0;
        void'($urandom(32'h8ba2d678));
        clearProgram("init");
        resetAndFetch();
        immediateOps();
        registerOps();
        forwardingChain();
        suppressedWrites();
        $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, totalErrs);
        if (totalErrs == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Encoders and reference model functions
    `include "rvEncode.svh"

endmodule

`default_nettype wire

//--- logic/rvCore.sv
`timescale 1ns/1ps
`default_nettype none

module rvCore (
    input  logic              clk,
    input  logic              rst_n,
    output rvIsaPkg::wordT    imemAddr,
    input  rvIsaPkg::wordT    imemInsn,
    output logic              retireValid,
    output rvIsaPkg::regAddrT retireReg,
    output rvIsaPkg::wordT    retireData
);
    import rvIsaPkg::*;

    wordT fetchPc;      // IF/ID contents
    wordT fetchInsn;
    logic fetchValid;

    issueIf issueBus ();  // ID/EX register

    fetchUnit fetchUnit_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .imemAddr   (imemAddr),
        .imemInsn   (imemInsn),
        .fetchPc    (fetchPc),
        .fetchInsn  (fetchInsn),
        .fetchValid (fetchValid)
    );

    // Write-back loops back into decode, same signals leave as retire port
    decodeStage decodeStage_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetchInsn  (fetchInsn),
        .fetchPc    (fetchPc),
        .fetchValid (fetchValid),
        .wbValid    (retireValid),
        .wbReg      (retireReg),
        .wbData     (retireData),
        .issue      (issueBus.decode)
    );

    executeStage executeStage_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .issue   (issueBus.execute),
        .wbValid (retireValid),
        .wbReg   (retireReg),
        .wbData  (retireData)
    );

endmodule

`default_nettype wire

//--- logic/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  logic              clk,
    input  logic              rst_n,
    issueIf.execute           issue,
    output logic              wbValid,
    output rvIsaPkg::regAddrT wbReg,
    output rvIsaPkg::wordT    wbData
);
    import rvIsaPkg::*;
    import rvPipePkg::*;

    logic    exWrite;       // Instruction in EX will write a register
    logic    exMemWrite;
    regAddrT exMemRd;
    wordT    exMemResult;
    logic    memWbWrite;
    regAddrT memWbRd;
    wordT    memWbResult;
    fwdSelE  fwdA;
    fwdSelE  fwdB;
    wordT    opA;
    wordT    regB;
    wordT    opB;
    wordT    aluResult;

    // ------------------------------
    // Forwarding
    function automatic fwdSelE pickSource(input regAddrT src);
        if (exMemWrite && exMemRd == src)
            return FROM_MEM;   // Nearest producer wins
        else if (memWbWrite && memWbRd == src)
            return FROM_WB;
        else
            return REGFILE;
    endfunction

    function automatic wordT pickOperand(input fwdSelE sel, input wordT fileVal);
        case (sel)
            FROM_MEM: return exMemResult;
            FROM_WB:  return memWbResult;
            default:  return fileVal;
        endcase
    endfunction

    always_comb begin
        fwdA = pickSource(issue.rs1);
        fwdB = pickSource(issue.rs2);
        opA  = pickOperand(fwdA, issue.rs1Data);
        regB = pickOperand(fwdB, issue.rs2Data);
        opB  = issue.useImm ? issue.imm : regB;   // OP-IMM
    end

    aluUnit aluUnit_inst (
        .op     (issue.aluOp),
        .a      (opA),
        .b      (opB),
        .result (aluResult)
    );

    // x0 writes and bubbles drop out here
    assign exWrite = issue.valid && issue.regWrite && (issue.rd != '0);

    // ------------------------------
    // EX/MEM and MEM/WB registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exMemWrite <= 1'b0;
            memWbWrite <= 1'b0;
        end else begin
            exMemWrite <= exWrite;
            memWbWrite <= exMemWrite;   // Memory slot passes through
        end
    end

    always_ff @(posedge clk) begin
        exMemRd     <= issue.rd;
        exMemResult <= aluResult;
        memWbRd     <= exMemRd;
        memWbResult <= exMemResult;
    end

    // Write-back, also the retire port
    assign wbValid = memWbWrite;
    assign wbReg   = memWbRd;
    assign wbData  = memWbResult;

endmodule

`default_nettype wire

//--- logic/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
    input  logic              clk,
    input  logic              rst_n,
    input  rvIsaPkg::wordT    fetchInsn,
    input  rvIsaPkg::wordT    fetchPc,
    input  logic              fetchValid,
    input  logic              wbValid,
    input  rvIsaPkg::regAddrT wbReg,
    input  rvIsaPkg::wordT    wbData,
    issueIf.decode            issue
);
    import rvIsaPkg::*;
    import rvPipePkg::*;

    regAddrT             rd;
    regAddrT             rs1;
    regAddrT             rs2;
    funct3T              funct3;
    logic                altBit;
    logic [IMM_BITS-1:0] immRaw;
    opcodeE              opcode;
    aluOpE               aluOp;
    logic                isShift;
    wordT                imm;
    wordT                rs1Data;
    wordT                rs2Data;
    logic                writes;

    // ------------------------------
    // Field extraction
    assign rd     = fetchInsn[RD_LSB +: $bits(regAddrT)];
    assign rs1    = fetchInsn[RS1_LSB +: $bits(regAddrT)];
    assign rs2    = fetchInsn[RS2_LSB +: $bits(regAddrT)];
    assign funct3 = fetchInsn[FUNCT3_LSB +: $bits(funct3T)];
    assign altBit = fetchInsn[ALT_BIT];
    assign immRaw = fetchInsn[IMM_LSB +: IMM_BITS];

    always_comb begin
        case (fetchInsn[OPCODE_BITS-1:0])
            OP_IMM:  opcode = OP_IMM;
            OP:      opcode = OP;
            default: opcode = OTHER;   // Loads, stores, branches etc.
        endcase
    end

    // Alt bit means SUB only for register ops, SRA for both groups
    always_comb begin
        case (funct3)
            F3_ADD:  aluOp = (opcode == OP && altBit) ? SUB : ADD;
            F3_SLL:  aluOp = SLL;
            F3_SLT:  aluOp = SLT;
            F3_SLTU: aluOp = SLTU;
            F3_XOR:  aluOp = XOR;
            F3_SR:   aluOp = altBit ? SRA : SRL;
            F3_OR:   aluOp = OR;
            F3_AND:  aluOp = AND;
        endcase
    end

    assign isShift = (funct3 == F3_SLL) || (funct3 == F3_SR);

    // Shift immediates keep only the shift amount
    always_comb begin
        if (isShift)
            imm = wordT'(shamtT'(immRaw));
        else
            imm = {{($bits(wordT) - IMM_BITS){immRaw[IMM_BITS-1]}}, immRaw};
    end

    // Unknown opcode or misaligned fetch goes down as a bubble
    assign writes = fetchValid && (opcode != OTHER) && (fetchPc[1:0] == 2'b00);

    regFile regFile_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs1     (rs1),
        .rs2     (rs2),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .wrEn    (wbValid),
        .wrReg   (wbReg),
        .wrData  (wbData)
    );

    // ------------------------------
    // ID/EX register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue.valid    <= 1'b0;
            issue.regWrite <= 1'b0;
        end else begin
            issue.valid    <= fetchValid;
            issue.regWrite <= writes;
        end
    end

    always_ff @(posedge clk) begin
        issue.aluOp   <= aluOp;
        issue.rs1     <= rs1;
        issue.rs2     <= rs2;
        issue.rd      <= rd;
        issue.rs1Data <= rs1Data;
        issue.rs2Data <= rs2Data;
        issue.imm     <= imm;
        issue.useImm  <= (opcode == OP_IMM);
    end

endmodule

`default_nettype wire

//--- logic/fetchUnit.sv
`timescale 1ns/1ps
`default_nettype none

module fetchUnit (
    input  logic           clk,
    input  logic           rst_n,
    output rvIsaPkg::wordT imemAddr,
    input  rvIsaPkg::wordT imemInsn,
    output rvIsaPkg::wordT fetchPc,
    output rvIsaPkg::wordT fetchInsn,
    output logic           fetchValid
);
    import rvIsaPkg::*;
    import rvPipePkg::*;

    wordT pc;

    assign imemAddr = pc;   // Memory answers in the same cycle

    // No stalls, PC steps every cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc         <= RESET_PC;
            fetchValid <= 1'b0;
        end else begin
            pc         <= pc + PC_STEP;
            fetchValid <= 1'b1;  // First capture after reset
        end
    end

    // IF/ID payload
    always_ff @(posedge clk) begin
        fetchPc   <= pc;
        fetchInsn <= imemInsn;
    end

endmodule

`default_nettype wire

//--- logic/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic              clk,
    input  logic              rst_n,
    input  rvIsaPkg::regAddrT rs1,
    input  rvIsaPkg::regAddrT rs2,
    output rvIsaPkg::wordT    rs1Data,
    output rvIsaPkg::wordT    rs2Data,
    input  logic              wrEn,
    input  rvIsaPkg::regAddrT wrReg,
    input  rvIsaPkg::wordT    wrData
);
    import rvIsaPkg::*;

    wordT regs [1:31];   // x0 has no storage

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (wrEn && wrReg != '0) begin
            regs[wrReg] <= wrData;
        end
    end

    // Same-cycle write is visible on the read ports
    assign rs1Data = (rs1 == '0) ? '0 : (wrEn && wrReg == rs1) ? wrData : regs[rs1];
    assign rs2Data = (rs2 == '0) ? '0 : (wrEn && wrReg == rs2) ? wrData : regs[rs2];

endmodule

`default_nettype wire

//--- logic/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
    input  rvPipePkg::aluOpE op,
    input  rvIsaPkg::wordT   a,
    input  rvIsaPkg::wordT   b,
    output rvIsaPkg::wordT   result
);
    import rvIsaPkg::*;
    import rvPipePkg::*;

    shamtT shamt;
    logic  lessSigned;
    logic  lessUnsigned;

    assign shamt        = shamtT'(b);   // Low five bits only
    assign lessSigned   = $signed(a) < $signed(b);
    assign lessUnsigned = a < b;

    always_comb begin
        case (op)
            ADD:     result = a + b;
            SUB:     result = a - b;
            SLL:     result = a << shamt;
            SLT:     result = wordT'(lessSigned);
            SLTU:    result = wordT'(lessUnsigned);
            XOR:     result = a ^ b;
            SRL:     result = a >> shamt;
            SRA:     result = wordT'($signed(a) >>> shamt);  // Sign fill
            OR:      result = a | b;
            AND:     result = a & b;
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/issueIf.sv
`timescale 1ns/1ps
`default_nettype none

// Decode/execute register contents
interface issueIf;
    import rvIsaPkg::*;
    import rvPipePkg::*;

    logic    valid;
    aluOpE   aluOp;
    regAddrT rs1;
    regAddrT rs2;
    regAddrT rd;
    logic    regWrite;   // Cleared for bubbles
    wordT    rs1Data;
    wordT    rs2Data;
    wordT    imm;
    logic    useImm;     // Operand B from imm

    modport decode (
        output valid, aluOp, rs1, rs2, rd, regWrite, rs1Data, rs2Data, imm, useImm
    );

    modport execute (
        input valid, aluOp, rs1, rs2, rd, regWrite, rs1Data, rs2Data, imm, useImm
    );

endinterface

`default_nettype wire

//--- logic/rvPipePkg.sv
`default_nettype none

package rvPipePkg;

    // Shift amount, low bits of operand B
    typedef logic [4:0] shamtT;

    // ALU operations
    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND
    } aluOpE;

    // Operand sources for execute
    typedef enum logic [1:0] {
        REGFILE,    // Value read in decode
        FROM_MEM,   // Result one slot ahead
        FROM_WB     // Result two slots ahead
    } fwdSelE;

    localparam rvIsaPkg::wordT RESET_PC = 32'h0000_0000;

endpackage

`default_nettype wire

//--- logic/rvIsaPkg.sv
`default_nettype none

package rvIsaPkg;

    // Widths with a meaning
    typedef logic [4:0]  regAddrT;  // Register number
    typedef logic [31:0] wordT;     // Instruction or data word
    typedef logic [2:0]  funct3T;

    localparam int OPCODE_BITS = 7;
    localparam int IMM_BITS    = 12;

    // Major opcodes, only two groups supported
    typedef enum logic [OPCODE_BITS-1:0] {
        OTHER  = 7'b0000000,
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011
    } opcodeE;

    // ------------------------------
    // Field positions
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int IMM_LSB    = 20;   // I-type immediate
    localparam int ALT_BIT    = 30;   // SUB / SRA select

    // funct3 codes
    localparam funct3T F3_ADD  = 3'b000;
    localparam funct3T F3_SLL  = 3'b001;
    localparam funct3T F3_SLT  = 3'b010;
    localparam funct3T F3_SLTU = 3'b011;
    localparam funct3T F3_XOR  = 3'b100;
    localparam funct3T F3_SR   = 3'b101;  // SRL and SRA share it
    localparam funct3T F3_OR   = 3'b110;
    localparam funct3T F3_AND  = 3'b111;

    localparam wordT PC_STEP = 32'd4;

endpackage

`default_nettype wire
